/* Bender.yml */
package:
  name: video_timing_aux

sources:
  - video_pkg.sv
  - switch_debounce.sv
  - mode_ctrl.sv
  - video_timing.sv
  - sync_de_gen.sv
  - aux_window.sv
  - video_top.sv
  - target: simulation
    files:
      - tb_video_top.sv

/* aux_window.sv */
`timescale 1ns/1ps

module aux_window #(
	parameter int AUX_LEN = 32
) (
	input  logic                 clk50m_bufg,
	input  logic                 RSTBTN,
	input  video_pkg::raster_t   raster,
	output logic                 aux_req,
	input  logic                 aux_ack,
	input  video_pkg::aux_word_u aux_data,
	output logic                 ade,
	output video_pkg::aux_nib_t  aux_out
);
	import video_pkg::*;

	localparam int LEN_W = (AUX_LEN > 1) ? $clog2(AUX_LEN) : 1;

	typedef enum logic [1:0] {
		ST_FETCH_START,	// Waiting on the start column word
		ST_FETCH_PAY,	// Waiting on the payload word
		ST_ARMED,	// Pair loaded, watching for the column
		ST_WINDOW	// Window open, counting
	} state_t;

	state_t           state;
	logic [AUX_W-1:0] start_col;
	aux_nib_t         payload;
	logic [LEN_W-1:0] len_cnt;
	logic             take;	// Word accepted this cycle
	logic             hit;	// Start column reached in blanking

	assign take = aux_req && aux_ack;
	assign hit  = raster.hblnk && (AUX_W'(raster.hcount) == start_col);

	//////////////////////////////
	// Fetch and window FSM
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state   <= ST_FETCH_START;
			aux_req <= 1'b0;
			len_cnt <= '0;
		end else begin
			case (state)
				ST_FETCH_START, ST_FETCH_PAY: begin
					if (take) begin
						aux_req <= 1'b0;	// First ack cycle, drop req
						state   <= (state == ST_FETCH_START) ? ST_FETCH_PAY : ST_ARMED;
					end else if (!aux_req && !aux_ack) begin
						aux_req <= 1'b1;	// Previous ack gone, ask again
					end
				end
				ST_ARMED: begin
					if (hit) begin
						state   <= ST_WINDOW;
						len_cnt <= '0;
					end
				end
				default: begin	// ST_WINDOW
					if (len_cnt == LEN_W'(AUX_LEN - 1)) begin
						state <= ST_FETCH_START;	// Release the pair
					end else begin
						len_cnt <= len_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Word capture, same union read both ways
	always_ff @(posedge clk50m_bufg) begin
		if (take && (state == ST_FETCH_START)) begin
			start_col <= aux_data.start_col;
		end
		if (take && (state == ST_FETCH_PAY)) begin
			payload <= aux_data.nib;
		end
	end

	// Stage 2, lines up with vde
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			ade     <= 1'b0;
			aux_out <= '0;
		end else begin
			ade     <= (state == ST_WINDOW);
			aux_out <= (state == ST_WINDOW) ? payload : '0;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	a_req_after_ack_low: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		$rose(aux_req) |-> !aux_ack);

	// vde now reflects the live area two cycles back
	a_ade_outside_vde: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		ade |-> !$past(!raster.hblnk && !raster.vblnk, 2));

endmodule

/* files.f */
video_pkg.sv
switch_debounce.sv
mode_ctrl.sv
video_timing.sv
sync_de_gen.sv
aux_window.sv
video_top.sv
tb_video_top.sv

/* mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl (
	input  logic                   clk50m_bufg,
	input  logic                   RSTBTN,
	input  video_pkg::mode_t       sw_mode,
	input  logic                   sw_changed,
	output video_pkg::timing_cfg_t cfg,
	output logic                   restart,
	output video_pkg::mode_t       mode
);
	import video_pkg::*;

	//////////////////////////////
	// Mode register and table load
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			// Table for whatever the debouncer holds now
			mode    <= sw_mode;
			cfg     <= mode_timing(sw_mode);
			restart <= 1'b0;
		end else begin
			restart <= sw_changed;	// Raster restarts with the new table
			if (sw_changed) begin
				mode <= sw_mode;
				cfg  <= mode_timing(sw_mode);
			end
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	// Debouncer needs many cycles between commits
	a_restart_pulse: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		restart |=> !restart);

	// Every loaded table must be ordered within each direction
	a_cfg_order: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		(cfg.hsblnk < cfg.hssync) && (cfg.hssync < cfg.hesync) &&
		(cfg.hesync < cfg.heblnk) && (cfg.vsblnk < cfg.vssync) &&
		(cfg.vssync < cfg.vesync) && (cfg.vesync < cfg.veblnk));

endmodule

/* switch_debounce.sv */
`timescale 1ns/1ps

module switch_debounce #(
	parameter int DEBOUNCE_CYCLES = 65536
) (
	input  logic             clk50m_bufg,
	input  logic             RSTBTN,
	input  logic [3:0]       sw,
	output video_pkg::mode_t sw_mode,
	output logic             sw_changed
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [3:0]       sw_meta;	// First sync flop
	logic [3:0]       sw_sync;	// Second sync flop
	logic [3:0]       sw_cand;	// Value being timed
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta    <= '0;
			sw_sync    <= '0;
			sw_cand    <= '0;
			stable_cnt <= '0;
			sw_mode    <= '0;	// VGA code
			sw_changed <= 1'b0;
		end else begin
			sw_meta    <= sw;
			sw_sync    <= sw_meta;
			sw_changed <= 1'b0;
			if (sw_sync != sw_cand) begin	// Bounce, start timing again
				sw_cand    <= sw_sync;
				stable_cnt <= '0;
			end else if (stable_cnt != CNT_W'(DEBOUNCE_CYCLES - 1)) begin
				stable_cnt <= stable_cnt + 1'b1;
			end else if (sw_cand != sw_mode) begin
				sw_mode    <= sw_cand;	// Stable long enough, commit
				sw_changed <= 1'b1;
			end
		end
	end

endmodule

/* sync_de_gen.sv */
`timescale 1ns/1ps

module sync_de_gen (
	input  logic                   clk50m_bufg,
	input  logic                   RSTBTN,
	input  video_pkg::timing_cfg_t cfg,
	input  video_pkg::raster_t     raster,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   vde
);

	logic hsync_q;	// Stage 1, polarity applied
	logic vsync_q;
	logic active_q;	// Stage 1 live area

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			// Sync lines parked at the inactive level
			hsync_q  <= cfg.neg_pol;
			vsync_q  <= cfg.neg_pol;
			active_q <= 1'b0;
			hsync    <= cfg.neg_pol;
			vsync    <= cfg.neg_pol;
			vde      <= 1'b0;
		end else begin
			hsync_q  <= raster.hsync_raw ^ cfg.neg_pol;
			vsync_q  <= raster.vsync_raw ^ cfg.neg_pol;
			active_q <= !raster.hblnk && !raster.vblnk;
			// Stage 2 to the pins
			hsync    <= hsync_q;
			vsync    <= vsync_q;
			vde      <= active_q;
		end
	end

endmodule

/* tb_video_top.sv */
`timescale 1ns/1ps

module tb_video_top;
	import video_pkg::*;

	// One VGA frame, four lines of the widest mode per mode, margin
	localparam int TIMEOUT_CYCLES = 800 * 525 + 6 * 4 * 1688 + 20000;
	localparam int AUX_LEN        = 32;

	// VGA vertical reference table
	localparam int VGA_V_LIVE = 480;
	localparam int VGA_V_FP   = 11;
	localparam int VGA_V_SYNC = 2;
	localparam int VGA_V_BP   = 31;
	localparam int VGA_LINES  = VGA_V_LIVE + VGA_V_FP + VGA_V_SYNC + VGA_V_BP;

	logic        clk50m_bufg;
	logic        RSTBTN;
	logic [3:0]  sw;
	logic        aux_req;
	logic        aux_ack;
	aux_word_u   aux_data;
	logic        hsync;
	logic        vsync;
	logic        vde;
	logic        ade;
	aux_nib_t    aux_out;
	logic [10:0] hcount;
	logic [10:0] vcount;
	mode_t       mode;

	logic [11:0] aux_words[$];	// Words the source hands out, in order
	integer      seed = 32'hc238a41e;
	int          cycle_cnt = 0;
	int          errors = 0;

	video_top #(
		.DEBOUNCE_CYCLES (16),	// Short debounce for simulation
		.AUX_LEN         (AUX_LEN)
	) u_dut (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.aux_req     (aux_req),
		.aux_ack     (aux_ack),
		.aux_data    (aux_data),
		.hsync       (hsync),
		.vsync       (vsync),
		.vde         (vde),
		.ade         (ade),
		.aux_out     (aux_out),
		.hcount      (hcount),
		.vcount      (vcount),
		.mode        (mode)
	);

	initial clk50m_bufg = 1'b0;
	always #10 clk50m_bufg = ~clk50m_bufg;	// 50 MHz

	always @(posedge clk50m_bufg) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			stop_at_error();
		end
	end

	//////////////////////////////
	// Error handling
	//////////////////////////////
	task automatic stop_at_error();
		errors++;
		$display("Regression failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_at_error();
		end
	endtask

	task automatic expect_true(input bit ok, input string what);
		assert (ok) else begin
			$display("%s", what);
			stop_at_error();
		end
	endtask

	//////////////////////////////
	// Aux source, four-phase
	//////////////////////////////
	initial begin : aux_source
		int delay;
		aux_ack  = 1'b0;
		aux_data = '0;
		forever begin
			@(negedge clk50m_bufg);
			if (aux_req === 1'b1 && aux_ack === 1'b0 && aux_words.size() != 0) begin
				delay = 1 + ($random(seed) & 3);	// 1 to 4 cycles
				repeat (delay) @(posedge clk50m_bufg);
				aux_data <= aux_words.pop_front();
				aux_ack  <= 1'b1;
				do begin
					@(negedge clk50m_bufg);
				end while (aux_req === 1'b1);	// Hold until req drops
				@(posedge clk50m_bufg);
				aux_ack <= 1'b0;
			end
		end
	end

	// Reference horizontal tables, live + porches + sync
	function automatic void line_timing(input logic [3:0] code, output int total,
		output int sync_w, output bit active_low);
		int live;
		int fp;
		int bp;
		case (code)
			MODE_VGA:    {live, fp, sync_w, bp} = {32'd640, 32'd16, 32'd96, 32'd48};
			MODE_SVGA:   {live, fp, sync_w, bp} = {32'd800, 32'd40, 32'd128, 32'd88};
			MODE_XGA:    {live, fp, sync_w, bp} = {32'd1024, 32'd24, 32'd136, 32'd160};
			MODE_SXGA:   {live, fp, sync_w, bp} = {32'd1280, 32'd48, 32'd112, 32'd248};
			MODE_CAMERA: {live, fp, sync_w, bp} = {32'd1280, 32'd110, 32'd39, 32'd220};
			default:     {live, fp, sync_w, bp} = {32'd1280, 32'd110, 32'd40, 32'd220};
		endcase
		total      = live + fp + sync_w + bp;
		active_low = (code == MODE_VGA) || (code == MODE_XGA);
	endfunction

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic verify_reset_state();
		int n;
		repeat (16) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
		@(negedge clk50m_bufg);	// Last reset edge just passed
		check_value("mode", mode, MODE_VGA);
		check_value("vde", vde, 0);
		check_value("ade", ade, 0);
		check_value("aux_req", aux_req, 0);
		check_value("hsync", hsync, 1);	// VGA idles high
		check_value("vsync", vsync, 1);
		n = 0;
		while (aux_req !== 1'b1 && n < 8) begin
			@(negedge clk50m_bufg);
			n++;
		end
		expect_true(aux_req === 1'b1, "aux_req did not rise after reset release");
	endtask

	task automatic select_mode(input logic [3:0] code);
		int n;
		@(posedge clk50m_bufg);
		sw <= code;
		n = 0;
		do begin
			@(negedge clk50m_bufg);
			n++;
		end while (mode !== code && n < 64);	// Sync + debounce + load
		expect_true(mode === code, "mode output did not follow the switches");
		repeat (4) @(negedge clk50m_bufg);	// Old pipeline flushed
	endtask

	task automatic measure_hsync(input logic [3:0] code);
		int   total;
		int   sync_w;
		bit   active_low;
		logic act;
		int   width;
		int   period;
		int   line;
		line_timing(code, total, sync_w, active_low);
		act = !active_low;
		check_value("hsync idle level", hsync, active_low);	// Line just restarted
		while (hsync !== act) begin
			@(negedge clk50m_bufg);
		end
		for (line = 0; line < 3; line++) begin
			width = 0;
			while (hsync === act) begin
				width++;
				@(negedge clk50m_bufg);
			end
			period = width;
			while (hsync !== act) begin
				period++;
				@(negedge clk50m_bufg);
			end
			check_value("hsync width", width, sync_w);
			check_value("hsync period", period, total);
		end
	endtask

	// Six listed codes plus one unlisted, VGA last for the frame scan
	task automatic sweep_modes();
		mode_t codes [7] = '{MODE_SVGA, MODE_HD720, MODE_XGA, MODE_SXGA,
			MODE_CAMERA, 4'b0101, MODE_VGA};
		foreach (codes[i]) begin
			select_mode(codes[i]);
			measure_hsync(codes[i]);
		end
	endtask

	task automatic scan_vga_frame();
		int   run;
		int   lines;
		int   vs_cycles;
		int   vs_runs;
		logic vs_prev;
		while (hcount !== 11'd700) begin
			@(negedge clk50m_bufg);	// Start in blanking, vde low
		end
		check_value("vsync idle level", vsync, 1);
		run       = 0;
		lines     = 0;
		vs_cycles = 0;
		vs_runs   = 0;
		vs_prev   = vsync;
		repeat (800 * VGA_LINES) begin	// Exactly one frame
			@(negedge clk50m_bufg);
			if (vde === 1'b1) begin
				run++;
			end else if (run != 0) begin
				check_value("vde cycles per line", run, 640);
				lines++;
				run = 0;
			end
			if (vsync === 1'b0) begin	// Active low
				vs_cycles++;
				if (vs_prev === 1'b1) begin
					vs_runs++;
					// First sync line, counters run two cycles ahead
					check_value("vcount at vsync start", vcount, VGA_V_LIVE + VGA_V_FP);
				end
			end
			vs_prev = vsync;
			check_value("ade", ade, 0);	// Nothing queued yet
		end
		check_value("vde lines", lines, VGA_V_LIVE);
		check_value("vsync pulses", vs_runs, 1);
		check_value("vsync width in lines", vs_cycles / 800, VGA_V_SYNC);
		check_value("vsync width in cycles", vs_cycles, VGA_V_SYNC * 800);
	endtask

	task automatic run_aux_window(input logic [11:0] start_col, input logic [11:0] payload);
		int n;
		@(posedge clk50m_bufg);
		aux_words.push_back(start_col);
		aux_words.push_back(payload);
		n = 0;
		while (ade !== 1'b1 && n < 3 * 800) begin
			@(negedge clk50m_bufg);
			n++;
		end
		expect_true(ade === 1'b1, "no aux window opened after the pair was queued");
		check_value("hcount at first ade", hcount, start_col + 2);
		n = 0;
		while (ade === 1'b1) begin
			check_value("aux_out", aux_out, payload);
			check_value("vde during ade", vde, 0);
			n++;
			@(negedge clk50m_bufg);
		end
		check_value("ade length", n, AUX_LEN);
	endtask

	// Source holds back for a whole line
	task automatic starve_aux_source();
		repeat (800) begin
			@(negedge clk50m_bufg);
			check_value("ade while starved", ade, 0);
		end
		check_value("aux_req while starved", aux_req, 1);
	endtask

	initial begin
		RSTBTN = 1'b1;
		sw     = 4'b0000;
		verify_reset_state();
		sweep_modes();
		scan_vga_frame();
		run_aux_window(12'd700, 12'hA5C);
		starve_aux_source();
		run_aux_window(12'd720, 12'h3C7);	// Late pair, new column
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* video_pkg.sv */
package video_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int CNT_W = 11;	// Pixel and line counters
	localparam int AUX_W = 12;	// One aux word
	localparam int NIB_W = 4;	// One aux nibble

	// Switch codes, anything unlisted runs as HD720
	typedef logic [3:0] mode_t;

	localparam mode_t MODE_VGA    = 4'b0000;
	localparam mode_t MODE_SVGA   = 4'b0001;
	localparam mode_t MODE_HD720  = 4'b0010;
	localparam mode_t MODE_XGA    = 4'b0011;
	localparam mode_t MODE_SXGA   = 4'b1000;
	localparam mode_t MODE_CAMERA = 4'b1001;

	// Cumulative counter limits, 89 bits
	typedef struct packed {
		logic [CNT_W-1:0] hsblnk;	// Last live pixel
		logic [CNT_W-1:0] hssync;	// Front porch end
		logic [CNT_W-1:0] hesync;	// Sync pulse end
		logic [CNT_W-1:0] heblnk;	// Last pixel of the line
		logic [CNT_W-1:0] vsblnk;
		logic [CNT_W-1:0] vssync;
		logic [CNT_W-1:0] vesync;
		logic [CNT_W-1:0] veblnk;
		logic             neg_pol;	// 1 = sync pulses active low
	} timing_cfg_t;

	// Raw raster straight off the counters
	typedef struct packed {
		logic [CNT_W-1:0] hcount;
		logic [CNT_W-1:0] vcount;
		logic             hblnk;
		logic             vblnk;
		logic             hsync_raw;
		logic             vsync_raw;
	} raster_t;

	typedef struct packed {
		logic [NIB_W-1:0] aux2;	// MS nibble
		logic [NIB_W-1:0] aux1;
		logic [NIB_W-1:0] aux0;
	} aux_nib_t;

	// First word of a pair is the start column, second the payload
	typedef union packed {
		logic [AUX_W-1:0] start_col;
		aux_nib_t         nib;
	} aux_word_u;

	//////////////////////////////
	// Timing tables
	//////////////////////////////
	// Live size, porches and sync width summed into counter limits
	function automatic timing_cfg_t make_cfg(
		input logic [CNT_W-1:0] hpix, hfp, hsw, hbp,
		input logic [CNT_W-1:0] vlin, vfp, vsw, vbp,
		input logic             neg
	);
		timing_cfg_t c;
		c.hsblnk  = hpix - 1'b1;
		c.hssync  = c.hsblnk + hfp;
		c.hesync  = c.hssync + hsw;
		c.heblnk  = c.hesync + hbp;
		c.vsblnk  = vlin - 1'b1;
		c.vssync  = c.vsblnk + vfp;
		c.vesync  = c.vssync + vsw;
		c.veblnk  = c.vesync + vbp;
		c.neg_pol = neg;
		return c;
	endfunction

	// Args: live, front porch, sync, back porch per direction, polarity
	function automatic timing_cfg_t mode_timing(input mode_t m);
		case (m)
			MODE_VGA:    return make_cfg(640, 16, 96, 48, 480, 11, 2, 31, 1'b1);
			MODE_SVGA:   return make_cfg(800, 40, 128, 88, 600, 1, 4, 23, 1'b0);
			MODE_XGA:    return make_cfg(1024, 24, 136, 160, 768, 3, 6, 29, 1'b1);
			MODE_SXGA:   return make_cfg(1280, 48, 112, 248, 1024, 1, 3, 38, 1'b0);
			MODE_CAMERA: return make_cfg(1280, 110, 39, 220, 720, 4, 4, 22, 1'b0);
			default:     return make_cfg(1280, 110, 40, 220, 720, 5, 5, 20, 1'b0);	// HD720
		endcase
	endfunction

endpackage

/* video_timing.sv */
`timescale 1ns/1ps

module video_timing (
	input  logic                   clk50m_bufg,
	input  logic                   RSTBTN,
	input  logic                   restart,
	input  video_pkg::timing_cfg_t cfg,
	output video_pkg::raster_t     raster
);
	import video_pkg::*;

	logic [CNT_W-1:0] hcount;
	logic [CNT_W-1:0] vcount;
	logic             h_end;	// Last pixel of the line
	logic             v_end;	// Last line of the frame

	assign h_end = (hcount >= cfg.heblnk);
	assign v_end = (vcount >= cfg.veblnk);

	//////////////////////////////
	// Pixel and line counters
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_end) begin
			hcount <= '0;
			if (v_end) begin
				vcount <= '0;	// Frame wrap
			end else begin
				vcount <= vcount + 1'b1;
			end
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// Flags decoded straight off the counters
	always_comb begin
		raster.hcount    = hcount;
		raster.vcount    = vcount;
		raster.hblnk     = (hcount > cfg.hsblnk);
		raster.vblnk     = (vcount > cfg.vsblnk);
		raster.hsync_raw = (hcount > cfg.hssync) && (hcount <= cfg.hesync);
		raster.vsync_raw = (vcount > cfg.vssync) && (vcount <= cfg.vesync);
	end

	// New table arrives with restart, counters are cleared the cycle after
	a_hcount_range: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!restart |-> (hcount <= cfg.heblnk));

endmodule

/* video_top.sv */
`timescale 1ns/1ps

module video_top #(
	parameter int DEBOUNCE_CYCLES = 65536,
	parameter int AUX_LEN         = 32
) (
	input  logic                 clk50m_bufg,
	input  logic                 RSTBTN,
	input  logic [3:0]           sw,
	output logic                 aux_req,
	input  logic                 aux_ack,
	input  video_pkg::aux_word_u aux_data,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 vde,
	output logic                 ade,
	output video_pkg::aux_nib_t  aux_out,
	output logic [10:0]          hcount,
	output logic [10:0]          vcount,
	output video_pkg::mode_t     mode
);
	import video_pkg::*;

	mode_t       sw_mode;
	logic        sw_changed;
	timing_cfg_t cfg;
	logic        restart;
	raster_t     raster;

	// Raw counters out, no delay
	assign hcount = raster.hcount;
	assign vcount = raster.vcount;

	//////////////////////////////
	// Mode select
	//////////////////////////////
	switch_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_switch_debounce (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.sw_mode     (sw_mode),
		.sw_changed  (sw_changed)
	);

	mode_ctrl u_mode_ctrl (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw_mode     (sw_mode),
		.sw_changed  (sw_changed),
		.cfg         (cfg),
		.restart     (restart),
		.mode        (mode)
	);

	//////////////////////////////
	// Raster, sync and aux
	//////////////////////////////
	video_timing u_video_timing (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.restart     (restart),
		.cfg         (cfg),
		.raster      (raster)
	);

	sync_de_gen u_sync_de_gen (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.cfg         (cfg),
		.raster      (raster),
		.hsync       (hsync),
		.vsync       (vsync),
		.vde         (vde)
	);

	aux_window #(.AUX_LEN(AUX_LEN)) u_aux_window (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.raster      (raster),
		.aux_req     (aux_req),
		.aux_ack     (aux_ack),
		.aux_data    (aux_data),
		.ade         (ade),
		.aux_out     (aux_out)
	);

endmodule
